// File: logic/corr_cfg_pkg.sv
// Correlator size defaults and baseline index helpers, imported by the design blocks.
package corr_cfg_pkg;

	localparam int NUM_INPUTS_DEF = 4;
	localparam int WORD_WIDTH_DEF = 2;
	localparam int NUM_LAGS_DEF   = 4;
	localparam int RESOLUTION_DEF = 12;

	// Unordered input pairs.
	function automatic int num_baselines(input int n_inputs);
		return n_inputs * (n_inputs - 1) / 2;
	endfunction

	// Pairs run (0,1), (0,2) .. (1,2) ..
	function automatic int baseline_first(input int bl, input int n_inputs);
		int idx;
		idx = 0;
		for (int a = 0; a < n_inputs; a++) begin
			for (int b = a + 1; b < n_inputs; b++) begin
				if (idx == bl) begin
					return a;
				end
				idx++;
			end
		end
		return 0;
	endfunction

	function automatic int baseline_second(input int bl, input int n_inputs);
		int idx;
		idx = 0;
		for (int a = 0; a < n_inputs; a++) begin
			for (int b = a + 1; b < n_inputs; b++) begin
				if (idx == bl) begin
					return b;
				end
				idx++;
			end
		end
		return 1;
	endfunction

endpackage

// File: logic/corr_ops_pkg.sv
// Correlation mode and history fill state types shared by the correlator blocks.
package corr_ops_pkg;

	// Term formed per baseline and lag.
	typedef enum logic [0:0] {
		MODE_PRODUCT    = 1'b0,
		MODE_DIFFERENCE = 1'b1
	} corr_mode_e;

	// Fill state of the lag history.
	typedef enum logic [1:0] {
		HIST_EMPTY   = 2'd0,
		HIST_FILLING = 2'd1,
		HIST_FULL    = 2'd2
	} hist_state_e;

endpackage

// File: logic/sample_if.sv
// Captured sample set passed from the capture stage to the delay line.
interface sample_if #(
	parameter int NUM_INPUTS = corr_cfg_pkg::NUM_INPUTS_DEF,
	parameter int WORD_WIDTH = corr_cfg_pkg::WORD_WIDTH_DEF
);
	import corr_ops_pkg::*;

	// Samples and mode are only meaningful while stb is high.
	logic                                  stb;
	logic [NUM_INPUTS-1:0][WORD_WIDTH-1:0] samples;
	corr_mode_e                            mode;
	logic                                  clear;

	modport producer (
		output stb, samples, mode, clear
	);

	modport buffer (
		input stb, samples, mode, clear
	);

endinterface

// File: logic/tap_if.sv
// Lag taps and mode passed from the delay line to the lag correlator.
interface tap_if #(
	parameter int NUM_INPUTS = corr_cfg_pkg::NUM_INPUTS_DEF,
	parameter int WORD_WIDTH = corr_cfg_pkg::WORD_WIDTH_DEF,
	parameter int NUM_LAGS   = corr_cfg_pkg::NUM_LAGS_DEF
);
	import corr_ops_pkg::*;

	// taps[i][0] is the newest sample of input i, taps[i][k] is k strobes older.
	logic                                                stb;
	logic [NUM_INPUTS-1:0][NUM_LAGS-1:0][WORD_WIDTH-1:0] taps;
	corr_mode_e                                          mode;
	logic                                                clear;

	modport buffer (
		output stb, taps, mode, clear
	);

	modport consumer (
		input stb, taps, mode, clear
	);

endinterface

// File: logic/sample_capture.sv
// Input stage of the correlator; registers samples, mode and clear on the sample strobe.
module sample_capture #(
	parameter int NUM_INPUTS = corr_cfg_pkg::NUM_INPUTS_DEF,
	parameter int WORD_WIDTH = corr_cfg_pkg::WORD_WIDTH_DEF
) (
	input  logic                           clk,
	input  logic                           arst_n_i,
	input  logic                           enable_i,
	input  logic                           sample_stb_i,
	input  logic [NUM_INPUTS*WORD_WIDTH-1:0] adc_data_i,
	input  corr_ops_pkg::corr_mode_e       mode_i,
	sample_if.producer                     out_o
);

	logic take_sample;

	// Strobes are dropped while disabled.
	assign take_sample = sample_stb_i & enable_i;

	// --------------------
	// Control
	// --------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			out_o.stb   <= 1'b0;
			out_o.clear <= 1'b1;
		end else begin
			out_o.stb   <= take_sample;
			out_o.clear <= ~enable_i;
		end
	end

	// --------------------
	// Payload
	// --------------------
	// Mode latched together with its sample.
	always_ff @(posedge clk) begin
		if (take_sample) begin
			out_o.samples <= adc_data_i;
			out_o.mode    <= mode_i;
		end
	end

endmodule

// File: logic/delay_line.sv
// Lag history of the correlator; shifts samples per strobe and forwards taps once full.
module delay_line #(
	parameter int NUM_INPUTS = corr_cfg_pkg::NUM_INPUTS_DEF,
	parameter int WORD_WIDTH = corr_cfg_pkg::WORD_WIDTH_DEF,
	parameter int NUM_LAGS   = corr_cfg_pkg::NUM_LAGS_DEF
) (
	input  logic     clk,
	input  logic     arst_n_i,
	sample_if.buffer in_i,
	tap_if.buffer    out_o
);
	import corr_ops_pkg::*;

	localparam int CNT_W = $clog2(NUM_LAGS + 1);

	hist_state_e        state_q;
	hist_state_e        state_d;
	logic [CNT_W-1:0]   fill_cnt_q;
	logic [CNT_W-1:0]   fill_cnt_d;

	// --------------------
	// Fill FSM
	// --------------------
	always_comb begin
		state_d    = state_q;
		fill_cnt_d = fill_cnt_q;
		case (state_q)
			HIST_EMPTY, HIST_FILLING: begin
				if (in_i.stb) begin
					fill_cnt_d = fill_cnt_q + 1'b1;
					// Last missing word completes the history.
					if (fill_cnt_q == CNT_W'(NUM_LAGS - 1)) begin
						state_d = HIST_FULL;
					end else begin
						state_d = HIST_FILLING;
					end
				end
			end
			HIST_FULL: state_d = HIST_FULL;
			default:   state_d = HIST_EMPTY;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= HIST_EMPTY;
			fill_cnt_q  <= '0;
			out_o.stb   <= 1'b0;
			out_o.clear <= 1'b1;
		end else begin
			out_o.clear <= in_i.clear;
			if (in_i.clear) begin
				state_q    <= HIST_EMPTY;
				fill_cnt_q <= '0;
				out_o.stb  <= 1'b0;
			end else begin
				state_q    <= state_d;
				fill_cnt_q <= fill_cnt_d;
				out_o.stb  <= in_i.stb && (state_d == HIST_FULL);
			end
		end
	end

	// --------------------
	// Shift registers
	// --------------------
	always_ff @(posedge clk) begin
		if (in_i.clear) begin
			out_o.taps <= '0;
		end else if (in_i.stb) begin
			out_o.mode <= in_i.mode;
			for (int i = 0; i < NUM_INPUTS; i++) begin
				out_o.taps[i][0] <= in_i.samples[i];
				for (int k = 1; k < NUM_LAGS; k++) begin
					out_o.taps[i][k] <= out_o.taps[i][k-1];
				end
			end
		end
	end

endmodule

// File: logic/lag_correlator.sv
// Accumulation stage; adds one saturating correlation term per baseline and lag on each tap strobe.
module lag_correlator #(
	parameter int NUM_INPUTS = corr_cfg_pkg::NUM_INPUTS_DEF,
	parameter int WORD_WIDTH = corr_cfg_pkg::WORD_WIDTH_DEF,
	parameter int NUM_LAGS   = corr_cfg_pkg::NUM_LAGS_DEF,
	parameter int RESOLUTION = corr_cfg_pkg::RESOLUTION_DEF
) (
	input  logic     clk,
	input  logic     arst_n_i,
	tap_if.consumer  in_i,
	output logic [corr_cfg_pkg::num_baselines(NUM_INPUTS)*NUM_LAGS*RESOLUTION-1:0] acc_o,
	output logic [corr_cfg_pkg::num_baselines(NUM_INPUTS)*NUM_LAGS-1:0]            sat_o
);
	import corr_cfg_pkg::*;
	import corr_ops_pkg::*;

	localparam int NUM_BASELINES = num_baselines(NUM_INPUTS);
	localparam int TERM_W        = 2 * WORD_WIDTH;

	for (genvar b = 0; b < NUM_BASELINES; b++) begin : g_baseline
		localparam int IDX_A = baseline_first(b, NUM_INPUTS);
		localparam int IDX_B = baseline_second(b, NUM_INPUTS);

		for (genvar k = 0; k < NUM_LAGS; k++) begin : g_lag
			logic [TERM_W-1:0]     cur_ext;
			logic [TERM_W-1:0]     lag_ext;
			logic [TERM_W-1:0]     term;
			logic [RESOLUTION:0]   sum;
			logic [RESOLUTION-1:0] acc_q;
			logic                  sat_q;

			// Current sample of A against B from k strobes back.
			assign cur_ext = {{WORD_WIDTH{1'b0}}, in_i.taps[IDX_A][0]};
			assign lag_ext = {{WORD_WIDTH{1'b0}}, in_i.taps[IDX_B][k]};

			always_comb begin
				if (in_i.mode == MODE_PRODUCT) begin
					term = cur_ext * lag_ext;
				end else if (cur_ext > lag_ext) begin
					term = cur_ext - lag_ext;
				end else begin
					term = lag_ext - cur_ext;
				end
			end

			// Extra top bit flags overflow.
			assign sum = {1'b0, acc_q} + {{(RESOLUTION + 1 - TERM_W){1'b0}}, term};

			always_ff @(posedge clk or negedge arst_n_i) begin
				if (!arst_n_i) begin
					acc_q <= '0;
					sat_q <= 1'b0;
				end else if (in_i.clear) begin
					acc_q <= '0;
					sat_q <= 1'b0;
				end else if (in_i.stb) begin
					if (sum[RESOLUTION]) begin
						acc_q <= '1;
						sat_q <= 1'b1;
					end else begin
						acc_q <= sum[RESOLUTION-1:0];
					end
				end
			end

			assign acc_o[(b*NUM_LAGS + k)*RESOLUTION +: RESOLUTION] = acc_q;
			assign sat_o[b*NUM_LAGS + k]                            = sat_q;
		end
	end

endmodule

// File: logic/correlator_top.sv
// Correlator top level; wires capture, delay line and accumulators behind plain ports.
module correlator_top #(
	parameter int NUM_INPUTS = corr_cfg_pkg::NUM_INPUTS_DEF,
	parameter int WORD_WIDTH = corr_cfg_pkg::WORD_WIDTH_DEF,
	parameter int NUM_LAGS   = corr_cfg_pkg::NUM_LAGS_DEF,
	parameter int RESOLUTION = corr_cfg_pkg::RESOLUTION_DEF
) (
	input  logic                             clk,
	input  logic                             arst_n_i,
	input  logic                             enable_i,
	input  logic                             sample_stb_i,
	input  logic [NUM_INPUTS*WORD_WIDTH-1:0] adc_data_i,
	input  corr_ops_pkg::corr_mode_e         mode_i,
	output logic [corr_cfg_pkg::num_baselines(NUM_INPUTS)*NUM_LAGS*RESOLUTION-1:0] acc_o,
	output logic [corr_cfg_pkg::num_baselines(NUM_INPUTS)*NUM_LAGS-1:0]            sat_o
);

	sample_if #(
		.NUM_INPUTS(NUM_INPUTS),
		.WORD_WIDTH(WORD_WIDTH)
	) sample_bus ();

	tap_if #(
		.NUM_INPUTS(NUM_INPUTS),
		.WORD_WIDTH(WORD_WIDTH),
		.NUM_LAGS  (NUM_LAGS)
	) tap_bus ();

	sample_capture #(
		.NUM_INPUTS(NUM_INPUTS),
		.WORD_WIDTH(WORD_WIDTH)
	) i_sample_capture (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.enable_i    (enable_i),
		.sample_stb_i(sample_stb_i),
		.adc_data_i  (adc_data_i),
		.mode_i      (mode_i),
		.out_o       (sample_bus.producer)
	);

	delay_line #(
		.NUM_INPUTS(NUM_INPUTS),
		.WORD_WIDTH(WORD_WIDTH),
		.NUM_LAGS  (NUM_LAGS)
	) i_delay_line (
		.clk     (clk),
		.arst_n_i(arst_n_i),
		.in_i    (sample_bus.buffer),
		.out_o   (tap_bus.buffer)
	);

	lag_correlator #(
		.NUM_INPUTS(NUM_INPUTS),
		.WORD_WIDTH(WORD_WIDTH),
		.NUM_LAGS  (NUM_LAGS),
		.RESOLUTION(RESOLUTION)
	) i_lag_correlator (
		.clk     (clk),
		.arst_n_i(arst_n_i),
		.in_i    (tap_bus.consumer),
		.acc_o   (acc_o),
		.sat_o   (sat_o)
	);

endmodule

// File: bench/correlator_assertions.sv
// Concurrent checks on strobe timing, fill state and clear; bound into the correlator top level.
module correlator_assertions #(
	parameter int NUM_INPUTS = corr_cfg_pkg::NUM_INPUTS_DEF,
	parameter int NUM_LAGS   = corr_cfg_pkg::NUM_LAGS_DEF,
	parameter int RESOLUTION = corr_cfg_pkg::RESOLUTION_DEF
) (
	input logic                      clk,
	input logic                      arst_n_i,
	input logic                      enable_i,
	input logic                      sample_stb_i,
	input logic                      cap_stb_i,
	input logic                      cap_clear_i,
	input logic                      tap_stb_i,
	input logic                      tap_clear_i,
	input corr_ops_pkg::hist_state_e hist_state_i,
	input logic [corr_cfg_pkg::num_baselines(NUM_INPUTS)*NUM_LAGS*RESOLUTION-1:0] acc_i
);
	timeunit 1ns;
	timeprecision 100ps;

	import corr_ops_pkg::*;

	int cap_count;

	// Captured strobes since the last clear.
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cap_count <= 0;
		end else if (cap_clear_i) begin
			cap_count <= 0;
		end else if (cap_stb_i && (cap_count < NUM_LAGS)) begin
			cap_count <= cap_count + 1;
		end
	end

	// Capture stage adds one cycle.
	cap_follows_stb: assert property (@(posedge clk) disable iff (!arst_n_i)
		enable_i |=> (cap_stb_i == $past(sample_stb_i)))
		else $error("captured strobe does not follow the sample strobe by one cycle");

	tap_only_when_full: assert property (@(posedge clk) disable iff (!arst_n_i)
		tap_stb_i |-> ((hist_state_i == HIST_FULL) && (cap_count >= NUM_LAGS)))
		else $error("tap strobe seen while the history is not full");

	// Accumulators empty right after a clear.
	acc_zero_after_clear: assert property (@(posedge clk) disable iff (!arst_n_i)
		tap_clear_i |=> (acc_i == '0))
		else $error("accumulators not zero one cycle after clear");

endmodule

bind correlator_top correlator_assertions #(
	.NUM_INPUTS(NUM_INPUTS),
	.NUM_LAGS  (NUM_LAGS),
	.RESOLUTION(RESOLUTION)
) i_correlator_assertions (
	.clk         (clk),
	.arst_n_i    (arst_n_i),
	.enable_i    (enable_i),
	.sample_stb_i(sample_stb_i),
	.cap_stb_i   (sample_bus.stb),
	.cap_clear_i (sample_bus.clear),
	.tap_stb_i   (tap_bus.stb),
	.tap_clear_i (tap_bus.clear),
	.hist_state_i(i_delay_line.state_q),
	.acc_i       (acc_o)
);

// File: bench/correlator_tb.sv
// Self-checking testbench for the correlator; random strobes are compared against a reference model.
module correlator_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import corr_cfg_pkg::*;
	import corr_ops_pkg::*;

	localparam int NI         = NUM_INPUTS_DEF;
	localparam int WW         = WORD_WIDTH_DEF;
	localparam int NL         = NUM_LAGS_DEF;
	localparam int RES        = RESOLUTION_DEF;
	localparam int NB         = NI * (NI - 1) / 2;
	localparam int ACC_MAX    = (1 << RES) - 1;
	localparam int CLK_PERIOD = 20;
	localparam int GAP        = 5;
	localparam int RAND_STB   = 200;
	localparam int SAT_STB    = 480;
	// Reset, ten checks, three enable changes and all strobe phases.
	localparam int RUN_CYCLES = 3 + 10 * (GAP + 1) + 3 + 8 + 2 * NL + 2 * RAND_STB + SAT_STB + 34;

	logic                 clk;
	logic                 arst_n_i;
	logic                 enable_i;
	logic                 sample_stb_i;
	logic [NI*WW-1:0]     adc_data_i;
	corr_mode_e           mode_i;
	logic [NB*NL*RES-1:0] acc_o;
	logic [NB*NL-1:0]     sat_o;

	int seed;
	int errors;
	int checks;
	int fill;
	int hist [NI][NL];
	int exp_acc [NB][NL];
	bit exp_sat [NB][NL];
	int pair_a [NB];
	int pair_b [NB];

	correlator_top i_correlator_top (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.enable_i    (enable_i),
		.sample_stb_i(sample_stb_i),
		.adc_data_i  (adc_data_i),
		.mode_i      (mode_i),
		.acc_o       (acc_o),
		.sat_o       (sat_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// --------------------
	// Reference model
	// --------------------
	task automatic model_clear();
		fill = 0;
		for (int i = 0; i < NI; i++) begin
			for (int k = 0; k < NL; k++) begin
				hist[i][k] = 0;
			end
		end
		for (int b = 0; b < NB; b++) begin
			for (int k = 0; k < NL; k++) begin
				exp_acc[b][k] = 0;
				exp_sat[b][k] = 1'b0;
			end
		end
	endtask

	task automatic model_strobe(input logic [NI*WW-1:0] data, input corr_mode_e mode);
		int a;
		int c;
		int term;
		for (int i = 0; i < NI; i++) begin
			for (int k = NL - 1; k > 0; k--) begin
				hist[i][k] = hist[i][k-1];
			end
			hist[i][0] = int'(data[i*WW +: WW]);
		end
		if (fill < NL) begin
			fill++;
		end
		// Nothing accumulates until every lag holds a sample.
		if (fill == NL) begin
			for (int b = 0; b < NB; b++) begin
				for (int k = 0; k < NL; k++) begin
					a = hist[pair_a[b]][0];
					c = hist[pair_b[b]][k];
					if (mode == MODE_PRODUCT) begin
						term = a * c;
					end else begin
						term = (a > c) ? a - c : c - a;
					end
					if (exp_acc[b][k] + term > ACC_MAX) begin
						exp_acc[b][k] = ACC_MAX;
						exp_sat[b][k] = 1'b1;
					end else begin
						exp_acc[b][k] = exp_acc[b][k] + term;
					end
				end
			end
		end
	endtask

	// --------------------
	// Drivers and checks
	// --------------------
	task automatic send_strobe(input logic [NI*WW-1:0] data, input corr_mode_e mode);
		@(posedge clk);
		sample_stb_i <= 1'b1;
		adc_data_i   <= data;
		mode_i       <= mode;
		if (enable_i) begin
			model_strobe(data, mode);
		end
	endtask

	task automatic send_random(input int count, input bit random_mode);
		logic [NI*WW-1:0] data;
		corr_mode_e       mode;
		for (int n = 0; n < count; n++) begin
			data = (NI*WW)'($random(seed));
			mode = (random_mode && ($random(seed) & 1)) ? MODE_DIFFERENCE : MODE_PRODUCT;
			send_strobe(data, mode);
		end
	endtask

	task automatic set_enable(input bit en);
		@(posedge clk);
		sample_stb_i <= 1'b0;
		enable_i     <= en;
		if (!en) begin
			model_clear();
		end
	endtask

	task automatic check_outputs(input string label);
		logic [RES-1:0] got;
		repeat (GAP) begin
			@(posedge clk);
			sample_stb_i <= 1'b0;
		end
		@(negedge clk);
		for (int b = 0; b < NB; b++) begin
			for (int k = 0; k < NL; k++) begin
				got = acc_o[(b*NL + k)*RES +: RES];
				checks++;
				assert (int'(got) == exp_acc[b][k]) else begin
					$display("Error at %0t ns: %s, acc[%0d][%0d] is %0d, expected %0d",
						$time, label, b, k, got, exp_acc[b][k]);
					errors++;
				end
				assert (sat_o[b*NL + k] == exp_sat[b][k]) else begin
					$display("Error at %0t ns: %s, sat[%0d][%0d] is %0b, expected %0b",
						$time, label, b, k, sat_o[b*NL + k], exp_sat[b][k]);
					errors++;
				end
			end
		end
	endtask

	// --------------------
	// Test sequence
	// --------------------
	initial begin
		int bl;
		seed         = 36;
		errors       = 0;
		checks       = 0;
		clk          = 1'b0;
		arst_n_i     = 1'b0;
		enable_i     = 1'b0;
		sample_stb_i = 1'b0;
		adc_data_i   = '0;
		mode_i       = MODE_PRODUCT;
		bl           = 0;
		for (int a = 0; a < NI; a++) begin
			for (int b = a + 1; b < NI; b++) begin
				pair_a[bl] = a;
				pair_b[bl] = b;
				bl++;
			end
		end
		model_clear();
		repeat (3) @(posedge clk);
		arst_n_i <= 1'b1;

		check_outputs("reset");
		send_random(8, 1'b0);
		check_outputs("strobes while disabled");

		set_enable(1'b1);
		send_random(NL - 1, 1'b0);
		check_outputs("fill");
		send_random(1, 1'b0);
		check_outputs("first full strobe");

		send_random(RAND_STB, 1'b0);
		check_outputs("product mode");
		send_random(RAND_STB, 1'b1);
		check_outputs("difference mode");

		repeat (SAT_STB) send_strobe('1, MODE_PRODUCT);
		check_outputs("saturation");
		assert (&acc_o && &sat_o) else begin
			$display("Error at %0t ns: saturation, not every accumulator is clamped", $time);
			errors++;
		end

		// Clear in the middle of a run, then refill.
		send_random(10, 1'b1);
		set_enable(1'b0);
		send_random(4, 1'b1);
		check_outputs("clear");
		set_enable(1'b1);
		send_random(NL - 1, 1'b1);
		check_outputs("refill");
		send_random(20, 1'b1);
		check_outputs("after refill");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#((RUN_CYCLES + 100) * CLK_PERIOD);
		$display("Simulation timed out after %0d cycles", RUN_CYCLES + 100);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: sources.f
logic/corr_cfg_pkg.sv
logic/corr_ops_pkg.sv
logic/sample_if.sv
logic/tap_if.sv
logic/sample_capture.sv
logic/delay_line.sv
logic/lag_correlator.sv
logic/correlator_top.sv
bench/correlator_assertions.sv
bench/correlator_tb.sv

// File: Makefile
TOP = correlator_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir obj_dir -f sources.f

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
